//--- Makefile
TOP := mem_stage_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f mem_stage.f --top-module $(TOP)

obj_dir/V$(TOP): mem_stage.f $(wildcard *.sv)
	verilator --binary --timing --assert -f mem_stage.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- dmem_arbiter.sv
module dmem_arbiter (
    dmem_if.port                        ld,
    dmem_if.port                        st,
    output mem_pkg::bus_cmd_e           cmd,
    output logic [mem_pkg::xlen-1:0]    addr,
    output logic [mem_pkg::xlen-1:0]    wdata,
    output mem_pkg::mem_size_e          size,
    input  logic [mem_pkg::tag_w-1:0]   response
);

    logic ld_sel;
    logic st_req;

    // loads win whenever they ask
    assign ld_sel = (ld.cmd != mem_pkg::bus_none);
    assign st_req = (st.cmd != mem_pkg::bus_none);

    always_comb begin
        if (ld_sel) begin
            cmd   = ld.cmd;
            addr  = ld.addr;
            wdata = ld.wdata;
            size  = ld.size;
        end else begin
            cmd   = st.cmd;   // bus_none when the store is idle too
            addr  = st.addr;
            wdata = st.wdata;
            size  = st.size;
        end
    end

    // the loser sees zero and retries next cycle
    assign ld.response = ld_sel ? response : '0;
    assign st.response = (!ld_sel && st_req) ? response : '0;

endmodule

//--- dmem_if.sv
interface dmem_if;

    mem_pkg::bus_cmd_e            cmd;       // requested command
    logic [mem_pkg::xlen-1:0]     addr;      // byte address
    mem_pkg::mem_size_e           size;      // access width
    logic [mem_pkg::xlen-1:0]     wdata;     // store data
    logic [mem_pkg::tag_w-1:0]    response;  // accept tag, zero is a refusal
    logic [mem_pkg::tag_w-1:0]    tag;       // tag of returning load data

    // load or store unit side
    modport requester (
        output cmd,
        output addr,
        output size,
        output wdata,
        input  response,
        input  tag
    );

    // arbiter side, steers the accept tag back
    modport port (
        input  cmd,
        input  addr,
        input  size,
        input  wdata,
        output response
    );

endinterface

//--- load_unit.sv
module load_unit (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic                        start,
    input  pkt_pkg::mem_op_t            op,
    input  logic [mem_pkg::xlen-1:0]    opa,
    input  logic [mem_pkg::xlen-1:0]    opb,
    input  logic [mem_pkg::xlen-1:0]    rdata,
    input  logic [mem_pkg::tag_w-1:0]   tag,
    dmem_if.requester                   bus,
    output logic [mem_pkg::xlen-1:0]    result,
    output logic [4:0]                  dest,
    output logic                        done,
    output logic                        busy
);

    typedef enum logic [1:0] {
        st_idle  = 2'h0,  // nothing held
        st_issue = 2'h1,  // driving the load command
        st_wait  = 2'h2   // accepted, waiting for tagged data
    } state_e;

    state_e                      state_q;
    pkt_pkg::mem_op_t            op_q;
    logic [mem_pkg::xlen-1:0]    addr_q;
    logic [mem_pkg::tag_w-1:0]   tag_q;
    logic [mem_pkg::xlen-1:0]    ext_data;
    logic                        take;
    logic                        accepted;
    logic                        hit;
    logic                        byte_fill;
    logic                        half_fill;

    assign take     = start & op.valid & op.rd_mem & (state_q == st_idle);
    assign accepted = (state_q == st_issue) & (bus.response != '0);
    assign hit      = (state_q == st_wait) & (tag == tag_q);

    assign busy = (state_q != st_idle);

    // command held until the port returns a nonzero tag
    assign bus.cmd   = (state_q == st_issue) ? mem_pkg::bus_load : mem_pkg::bus_none;
    assign bus.addr  = addr_q;
    assign bus.size  = op_q.size;
    assign bus.wdata = '0;  // loads carry no data

    // fill bit is the sign only for signed loads
    assign byte_fill = ~op_q.is_unsigned & rdata[7];
    assign half_fill = ~op_q.is_unsigned & rdata[15];

    always_comb begin
        case (op_q.size)
            mem_pkg::size_byte: ext_data = {{(mem_pkg::xlen-8){byte_fill}}, rdata[7:0]};
            mem_pkg::size_half: ext_data = {{(mem_pkg::xlen-16){half_fill}}, rdata[15:0]};
            default:            ext_data = rdata;  // whole word
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
            op_q    <= pkt_pkg::mem_op_idle;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (take) begin
                        state_q <= st_issue;
                        op_q    <= op;
                    end
                end
                st_issue: begin
                    if (accepted) begin
                        state_q <= st_wait;
                    end
                end
                st_wait: begin
                    if (hit) begin
                        state_q <= st_idle;
                        op_q    <= pkt_pkg::mem_op_idle;
                        done    <= 1'b1;  // one cycle after the tag match
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            addr_q <= opa + opb;  // effective address
        end
        if (accepted) begin
            tag_q <= bus.response;
        end
        if (hit) begin
            result <= ext_data;
            dest   <= op_q.dest_reg;
        end
    end

endmodule

//--- mem_pkg.sv
package mem_pkg;

    // datapath width, shared by address and data
    localparam int xlen  = 32;

    // transaction tag width, zero is reserved
    localparam int tag_w = 4;

    // data-memory bus command
    typedef enum logic [1:0] {
        bus_none  = 2'h0,  // no request this cycle
        bus_load  = 2'h1,  // read one access
        bus_store = 2'h2   // write one access
    } bus_cmd_e;

    // access width on the bus
    typedef enum logic [1:0] {
        size_byte = 2'h0,  // 8 bits
        size_half = 2'h1,  // 16 bits
        size_word = 2'h2   // 32 bits
    } mem_size_e;

endpackage

//--- mem_stage.f
mem_pkg.sv
pkt_pkg.sv
dmem_if.sv
load_unit.sv
store_unit.sv
dmem_arbiter.sv
mem_stage.sv
mem_stage_asserts.sv
mem_stage_tb.sv

//--- mem_stage.sv
module mem_stage (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic                        start,
    input  logic [mem_pkg::xlen-1:0]    opa,
    input  logic [mem_pkg::xlen-1:0]    opb,
    input  logic [mem_pkg::xlen-1:0]    store_data,
    input  logic                        rd_mem,
    input  logic                        wr_mem,
    input  logic                        is_unsigned,
    input  mem_pkg::mem_size_e          size,
    input  logic [4:0]                  dest_reg,
    input  logic [mem_pkg::tag_w-1:0]   mem_response,
    input  logic [mem_pkg::tag_w-1:0]   mem_tag,
    input  logic [mem_pkg::xlen-1:0]    mem_rdata,
    output mem_pkg::bus_cmd_e           mem_cmd,
    output logic [mem_pkg::xlen-1:0]    mem_addr,
    output mem_pkg::mem_size_e          mem_size,
    output logic [mem_pkg::xlen-1:0]    mem_wdata,
    output logic [mem_pkg::xlen-1:0]    load_result,
    output logic [4:0]                  load_dest,
    output logic                        load_done,
    output logic                        store_done,
    output logic                        busy
);

    pkt_pkg::mem_op_t op;
    logic             ld_start;
    logic             st_start;
    logic             ld_busy;
    logic             st_busy;

    dmem_if ld_bus ();
    dmem_if st_bus ();

    // returning data tag goes to both requesters
    assign ld_bus.tag = mem_tag;
    assign st_bus.tag = mem_tag;

    always_comb begin
        op             = pkt_pkg::mem_op_idle;
        op.rd_mem      = rd_mem;
        op.wr_mem      = wr_mem;
        op.is_unsigned = is_unsigned;
        op.size        = size;
        op.dest_reg    = dest_reg;
        op.valid       = rd_mem | wr_mem;
    end

    assign ld_start = start & rd_mem;
    assign st_start = start & wr_mem & ~rd_mem;  // a load takes precedence

    // busy of whichever unit the current op would use
    assign busy = rd_mem ? ld_busy : (wr_mem & st_busy);

    load_unit i_load_unit (
        .clock  (clock),
        .arst_n (arst_n),
        .start  (ld_start),
        .op     (op),
        .opa    (opa),
        .opb    (opb),
        .rdata  (mem_rdata),
        .tag    (ld_bus.tag),
        .bus    (ld_bus.requester),
        .result (load_result),
        .dest   (load_dest),
        .done   (load_done),
        .busy   (ld_busy)
    );

    store_unit i_store_unit (
        .clock  (clock),
        .arst_n (arst_n),
        .start  (st_start),
        .opa    (opa),
        .opb    (opb),
        .wdata  (store_data),
        .size   (size),
        .bus    (st_bus.requester),
        .done   (store_done),
        .busy   (st_busy)
    );

    dmem_arbiter i_dmem_arbiter (
        .ld       (ld_bus.port),
        .st       (st_bus.port),
        .cmd      (mem_cmd),
        .addr     (mem_addr),
        .wdata    (mem_wdata),
        .size     (mem_size),
        .response (mem_response)
    );

endmodule

//--- mem_stage_asserts.sv
module mem_stage_asserts (
    input  logic                        clock,
    input  logic                        arst_n,
    input  mem_pkg::bus_cmd_e           mem_cmd,
    input  logic [mem_pkg::xlen-1:0]    mem_addr,
    input  logic [mem_pkg::tag_w-1:0]   mem_response,
    input  logic                        load_done,
    input  logic                        store_done
);

    // refused command stays on the bus unchanged
    hold_on_refusal: assert property (@(posedge clock) disable iff (!arst_n)
        (mem_cmd != mem_pkg::bus_none && mem_response == '0) |=>
            (mem_cmd == $past(mem_cmd) && mem_addr == $past(mem_addr)))
        else $error("bus command or address changed after a refusal");

    load_done_pulse: assert property (@(posedge clock) disable iff (!arst_n)
        load_done |=> !load_done)
        else $error("load_done held for more than one cycle");

    store_done_pulse: assert property (@(posedge clock) disable iff (!arst_n)
        store_done |=> !store_done)
        else $error("store_done held for more than one cycle");

    idle_after_reset: assert property (@(posedge clock)
        $rose(arst_n) |-> mem_cmd == mem_pkg::bus_none)
        else $error("bus command present right after reset");

endmodule

bind mem_stage mem_stage_asserts i_mem_stage_asserts (
    .clock        (clock),
    .arst_n       (arst_n),
    .mem_cmd      (mem_cmd),
    .mem_addr     (mem_addr),
    .mem_response (mem_response),
    .load_done    (load_done),
    .store_done   (store_done)
);

//--- mem_stage_tb.sv
module mem_stage_tb;

    typedef struct packed {
        logic                        is_load;
        logic [mem_pkg::xlen-1:0]    opa;
        logic [mem_pkg::xlen-1:0]    opb;
        mem_pkg::mem_size_e          size;
        logic                        uns;
        logic [mem_pkg::xlen-1:0]    data;
        logic [4:0]                  dest;
        logic [mem_pkg::xlen-1:0]    expect_val;  // load result, unused for stores
    } op_entry_t;

    localparam int wait_limit = 100;  // cycles

    logic                        clock;
    logic                        arst_n;
    logic                        start;
    logic [mem_pkg::xlen-1:0]    opa;
    logic [mem_pkg::xlen-1:0]    opb;
    logic [mem_pkg::xlen-1:0]    store_data;
    logic                        rd_mem;
    logic                        wr_mem;
    logic                        is_unsigned;
    mem_pkg::mem_size_e          size;
    logic [4:0]                  dest_reg;
    logic [mem_pkg::tag_w-1:0]   mem_response;
    logic [mem_pkg::tag_w-1:0]   mem_tag;
    logic [mem_pkg::xlen-1:0]    mem_rdata;
    mem_pkg::bus_cmd_e           mem_cmd;
    logic [mem_pkg::xlen-1:0]    mem_addr;
    mem_pkg::mem_size_e          mem_size;
    logic [mem_pkg::xlen-1:0]    mem_wdata;
    logic [mem_pkg::xlen-1:0]    load_result;
    logic [4:0]                  load_dest;
    logic                        load_done;
    logic                        store_done;
    logic                        busy;

    logic [mem_pkg::xlen-1:0]    mem [0:255];      // bus-side memory model
    logic [mem_pkg::xlen-1:0]    ref_mem [0:255];  // expected contents
    logic [15:0]                 lfsr;
    logic [mem_pkg::tag_w-1:0]   next_tag;
    logic                        rd_pending;
    int                          rd_delay;
    logic [mem_pkg::tag_w-1:0]   rd_tag;
    logic [mem_pkg::xlen-1:0]    rd_data;
    op_entry_t                   table_q [$];
    int                          errors;
    int                          tests;

    mem_stage i_mem_stage (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [31:0] fill_word(input int idx);
        logic [7:0] a;
        a = idx[7:0];
        return {a ^ 8'h5a, ~a, a + 8'h31, a * 8'd13};
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic take_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        take_bit = lfsr[15];
        lfsr = {lfsr[14:0], fb};
    endfunction

    function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] addr,
                                                input mem_pkg::mem_size_e sz,
                                                input logic [31:0] data);
        logic [31:0] mask;
        case (sz)
            mem_pkg::size_byte: mask = 32'h0000_00ff;
            mem_pkg::size_half: mask = 32'h0000_ffff;
            default:            mask = 32'hffff_ffff;
        endcase
        mask = mask << (8 * addr[1:0]);  // lane of the addressed byte
        return (old & ~mask) | ((data << (8 * addr[1:0])) & mask);
    endfunction

    function automatic logic [31:0] extend_load(input logic [31:0] word, input logic [31:0] addr,
                                                input mem_pkg::mem_size_e sz, input logic uns);
        logic [31:0] raw;
        raw = word >> (8 * addr[1:0]);
        if (sz == mem_pkg::size_byte) begin
            return uns ? {24'h0, raw[7:0]} : 32'($signed(raw[7:0]));
        end else if (sz == mem_pkg::size_half) begin
            return uns ? {16'h0, raw[15:0]} : 32'($signed(raw[15:0]));
        end
        return raw;
    endfunction

    // builds one entry and tracks its effect on the expected memory
    function automatic op_entry_t make_op(input logic is_load, input logic [31:0] a,
                                          input logic [31:0] b, input mem_pkg::mem_size_e sz,
                                          input logic uns, input logic [31:0] data,
                                          input logic [4:0] dest);
        op_entry_t   e;
        logic [31:0] addr;
        addr         = a + b;
        e.is_load    = is_load;
        e.opa        = a;
        e.opb        = b;
        e.size       = sz;
        e.uns        = uns;
        e.data       = data;
        e.dest       = dest;
        e.expect_val = '0;
        if (is_load) begin
            e.expect_val = extend_load(ref_mem[addr[9:2]], addr, sz, uns);
        end else begin
            ref_mem[addr[9:2]] = merge_store(ref_mem[addr[9:2]], addr, sz, data);
        end
        return e;
    endfunction

    // tagged memory, refuses on an lfsr bit, returns load data 2 to 5 cycles later
    initial begin : tagged_memory
        int         dly;
        logic [7:0] idx;
        mem_response = '0;
        mem_tag      = '0;
        mem_rdata    = '0;
        rd_pending   = 1'b0;
        rd_delay     = 0;
        rd_tag       = '0;
        rd_data      = '0;
        next_tag     = 4'd1;
        lfsr         = 16'd27;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        forever begin
            @(negedge clock);
            idx = mem_addr[9:2];
            mem_response <= '0;
            mem_tag      <= '0;
            if (!arst_n) begin
                rd_pending <= 1'b0;
                next_tag   <= 4'd1;
            end else begin
                if (rd_pending) begin
                    if (rd_delay == 1) begin
                        mem_tag    <= rd_tag;
                        mem_rdata  <= rd_data;
                        rd_pending <= 1'b0;
                    end
                    rd_delay <= rd_delay - 1;
                end
                if (mem_cmd != mem_pkg::bus_none && !take_bit()) begin
                    mem_response <= next_tag;
                    next_tag     <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;  // skip zero
                    if (mem_cmd == mem_pkg::bus_load) begin
                        dly = 2;
                        if (take_bit()) dly = dly + 2;
                        if (take_bit()) dly = dly + 1;
                        rd_pending <= 1'b1;
                        rd_delay   <= dly;
                        rd_tag     <= next_tag;
                        rd_data    <= mem[idx] >> (8 * mem_addr[1:0]);
                    end else begin
                        mem[idx] <= merge_store(mem[idx], mem_addr, mem_size, mem_wdata);
                    end
                end
            end
        end
    end

    task automatic check_result(input string name, input logic [mem_pkg::xlen-1:0] got,
                                input logic [mem_pkg::xlen-1:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_dest(input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            $display("Fail load_dest: got %h, expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_cmd(input mem_pkg::bus_cmd_e got, input mem_pkg::bus_cmd_e exp);
        if (got !== exp) begin
            $display("Fail mem_cmd: got %h, expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_size(input mem_pkg::mem_size_e got, input mem_pkg::mem_size_e exp);
        if (got !== exp) begin
            $display("Fail mem_size: got %h, expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_done(input logic is_load);
        int n;
        n = 0;
        while ((is_load ? load_done : store_done) !== 1'b1 && n < wait_limit) begin
            @(negedge clock);
            n++;
        end
        if ((is_load ? load_done : store_done) !== 1'b1) begin
            $display("timeout waiting for %s", is_load ? "load_done" : "store_done");
            errors++;
        end
    endtask

    // drives one start strobe, returns at the next falling edge
    task automatic issue(input op_entry_t e);
        opa         = e.opa;
        opb         = e.opb;
        store_data  = e.data;
        rd_mem      = e.is_load;
        wr_mem      = ~e.is_load;
        is_unsigned = e.uns;
        size        = e.size;
        dest_reg    = e.dest;
        start       = 1'b1;
        @(negedge clock);
        start = 1'b0;
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err0) ? "ok" : "error");
    endtask

    task automatic run_entry(input op_entry_t e);
        int err0;
        err0 = errors;
        issue(e);
        check_cmd(mem_cmd, e.is_load ? mem_pkg::bus_load : mem_pkg::bus_store);
        check_result("mem_addr", mem_addr, e.opa + e.opb);
        check_size(mem_size, e.size);
        if (!e.is_load) begin
            check_result("mem_wdata", mem_wdata, e.data);
        end
        wait_done(e.is_load);
        if (e.is_load) begin
            check_result("load_result", load_result, e.expect_val);
            check_dest(load_dest, e.dest);
        end
        report_test(e.is_load ? "load" : "store", err0);
    endtask

    initial begin : stimulus
        op_entry_t ld;
        op_entry_t st;
        int        err0;
        int        n;
        logic      ld_seen;
        logic      st_seen;
        errors      = 0;
        tests       = 0;
        arst_n      = 1'b0;
        start       = 1'b0;
        opa         = '0;
        opb         = '0;
        store_data  = '0;
        rd_mem      = 1'b0;
        wr_mem      = 1'b0;
        is_unsigned = 1'b0;
        size        = mem_pkg::size_byte;
        dest_reg    = '0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = fill_word(i);
        end

        table_q.push_back(make_op(1'b0, 32'h100, 32'h0, mem_pkg::size_word, 1'b0, 32'h8bad_f00d, 5'd0));
        table_q.push_back(make_op(1'b1, 32'h100, 32'h0, mem_pkg::size_word, 1'b1, 32'h0, 5'd1));
        table_q.push_back(make_op(1'b1, 32'h0f0, 32'h10, mem_pkg::size_byte, 1'b1, 32'h0, 5'd2));
        table_q.push_back(make_op(1'b1, 32'h104, 32'hffff_ffff, mem_pkg::size_byte, 1'b0, 32'h0, 5'd3));
        table_q.push_back(make_op(1'b1, 32'h100, 32'h0, mem_pkg::size_byte, 1'b0, 32'h0, 5'd4));
        table_q.push_back(make_op(1'b1, 32'h102, 32'h0, mem_pkg::size_half, 1'b0, 32'h0, 5'd5));
        table_q.push_back(make_op(1'b1, 32'h100, 32'h2, mem_pkg::size_half, 1'b1, 32'h0, 5'd6));
        table_q.push_back(make_op(1'b0, 32'h200, 32'h5, mem_pkg::size_byte, 1'b0, 32'h1234_56f0, 5'd0));
        table_q.push_back(make_op(1'b1, 32'h205, 32'h0, mem_pkg::size_byte, 1'b0, 32'h0, 5'd7));
        table_q.push_back(make_op(1'b1, 32'h204, 32'h0, mem_pkg::size_word, 1'b0, 32'h0, 5'd8));
        table_q.push_back(make_op(1'b0, 32'h308, 32'h2, mem_pkg::size_half, 1'b0, 32'hcafe_7ffe, 5'd0));
        table_q.push_back(make_op(1'b1, 32'h30a, 32'h0, mem_pkg::size_half, 1'b0, 32'h0, 5'd10));
        table_q.push_back(make_op(1'b1, 32'h308, 32'h0, mem_pkg::size_word, 1'b1, 32'h0, 5'd11));
        table_q.push_back(make_op(1'b1, 32'h0f0, 32'h3, mem_pkg::size_byte, 1'b0, 32'h0, 5'd12));
        table_q.push_back(make_op(1'b1, 32'h3fc, 32'h0, mem_pkg::size_word, 1'b0, 32'h0, 5'd31));
        table_q.push_back(make_op(1'b1, 32'h3fe, 32'h0, mem_pkg::size_half, 1'b0, 32'h0, 5'd30));

        repeat (2) @(negedge clock);
        arst_n = 1'b1;

        // idle bus and no completions straight out of reset
        err0   = errors;
        rd_mem = 1'b1;  // busy reports the load unit first
        repeat (4) begin
            @(negedge clock);
            check_cmd(mem_cmd, mem_pkg::bus_none);
            check_flag("load_done", load_done, 1'b0);
            check_flag("store_done", store_done, 1'b0);
            check_flag("busy", busy, 1'b0);
            rd_mem = ~rd_mem;  // alternate the unit behind busy
            wr_mem = ~rd_mem;
        end
        report_test("after reset", err0);

        foreach (table_q[i]) begin
            run_entry(table_q[i]);
        end

        // store slips in while the load waits for its tag
        err0 = errors;
        ld   = make_op(1'b1, 32'h300, 32'h8, mem_pkg::size_word, 1'b0, 32'h0, 5'd9);
        st   = make_op(1'b0, 32'h380, 32'h0, mem_pkg::size_word, 1'b0, 32'h1234_abcd, 5'd0);
        issue(ld);
        n = 0;
        while (rd_pending !== 1'b1 && n < wait_limit) begin
            @(negedge clock);
            n++;
        end
        if (rd_pending !== 1'b1) begin
            $display("timeout waiting for the load to be accepted");
            errors++;
        end
        issue(st);
        ld_seen = 1'b0;
        st_seen = 1'b0;
        n       = 0;
        while (!(ld_seen && st_seen) && n < wait_limit) begin
            if (load_done === 1'b1) begin
                ld_seen = 1'b1;
                check_result("load_result", load_result, ld.expect_val);
                check_dest(load_dest, ld.dest);
            end
            if (store_done === 1'b1) st_seen = 1'b1;
            @(negedge clock);
            n++;
        end
        if (!(ld_seen && st_seen)) begin
            $display("timeout waiting for load_done and store_done");
            errors++;
        end
        report_test("store during load", err0);

        // second start lands while busy and must be dropped
        err0 = errors;
        ld   = make_op(1'b1, 32'h380, 32'h0, mem_pkg::size_word, 1'b0, 32'h0, 5'd17);
        st   = make_op(1'b1, 32'h104, 32'h0, mem_pkg::size_byte, 1'b1, 32'h0, 5'd3);
        issue(ld);
        check_flag("busy", busy, 1'b1);
        issue(st);
        wait_done(1'b1);
        check_result("load_result", load_result, ld.expect_val);
        check_dest(load_dest, ld.dest);
        repeat (12) begin
            @(negedge clock);
            check_cmd(mem_cmd, mem_pkg::bus_none);
            if (load_done === 1'b1) begin
                $display("extra load_done after a start that should have been ignored");
                errors++;
            end
        end
        report_test("start while busy", err0);

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- pkt_pkg.sv
package pkt_pkg;

    // memory operation descriptor carried with a load
    typedef struct packed {
        logic                rd_mem;       // operation reads memory
        logic                wr_mem;       // operation writes memory
        logic                is_unsigned;  // zero-extend on load
        mem_pkg::mem_size_e  size;         // access width
        logic [4:0]          dest_reg;     // architectural destination
        logic                valid;        // descriptor holds an operation
    } mem_op_t;

    // cleared descriptor
    localparam mem_op_t mem_op_idle = '{
        rd_mem:      1'b0,
        wr_mem:      1'b0,
        is_unsigned: 1'b0,
        size:        mem_pkg::size_byte,
        dest_reg:    5'd0,
        valid:       1'b0
    };

endpackage

//--- store_unit.sv
module store_unit (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic                        start,
    input  logic [mem_pkg::xlen-1:0]    opa,
    input  logic [mem_pkg::xlen-1:0]    opb,
    input  logic [mem_pkg::xlen-1:0]    wdata,
    input  mem_pkg::mem_size_e          size,
    dmem_if.requester                   bus,
    output logic                        done,
    output logic                        busy
);

    logic                        pending_q;
    logic [mem_pkg::xlen-1:0]    addr_q;
    logic [mem_pkg::xlen-1:0]    data_q;
    mem_pkg::mem_size_e          size_q;
    logic                        take;
    logic                        accepted;

    assign take     = start & ~pending_q;
    assign accepted = pending_q & (bus.response != '0);

    assign busy = pending_q;

    // request stays up until a nonzero response
    assign bus.cmd   = pending_q ? mem_pkg::bus_store : mem_pkg::bus_none;
    assign bus.addr  = addr_q;
    assign bus.size  = size_q;
    assign bus.wdata = data_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pending_q <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= accepted;  // pulse after the accept cycle
            if (take) begin
                pending_q <= 1'b1;
            end else if (accepted) begin
                pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            addr_q <= opa + opb;
            data_q <= wdata;
            size_q <= size;
        end
    end

endmodule
